// File: execCore.f
logic/execPkg.sv
logic/execIf.sv
logic/reorderBuffer.sv
logic/reservationStation.sv
logic/aluUnit.sv
logic/execCore.sv
tb/execCoreTb.sv

// File: logic/aluUnit.sv
// Integer ALU stage
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  logic   clk,
    input  logic   rstN,
    issueIf.dst    issue,
    resultIf.drv   result
);
    import execPkg::*;

    logic                  fire;
    logic [dataWidth-1:0]  sum;
    logic [shamtWidth-1:0] shamt;
    logic [dataWidth-1:0]  dataD;
    logic                  jumpEnD;
    logic [addrWidth-1:0]  jumpAddrD;

    // the broadcast is never refused so no result is ever held back
    assign issue.ready = 1'b1;
    assign fire        = issue.valid & issue.ready;

    assign sum   = issue.opA + issue.opB;
    assign shamt = issue.opB[shamtWidth-1:0];

    // --------------------------------------------------
    // decode
    always_comb begin
        dataD     = dataFree;
        jumpEnD   = 1'b0;
        jumpAddrD = addrFree;
        case (issue.op)
            opAdd:   dataD = sum;
            opSub:   dataD = issue.opA - issue.opB;
            opSll:   dataD = issue.opA << shamt;
            opSlt:   dataD = dataWidth'($signed(issue.opA) < $signed(issue.opB));
            opSltu:  dataD = dataWidth'(issue.opA < issue.opB);
            opXor:   dataD = issue.opA ^ issue.opB;
            opSrl:   dataD = issue.opA >> shamt;
            opSra:   dataD = $signed(issue.opA) >>> shamt;
            opOr:    dataD = issue.opA | issue.opB;
            opAnd:   dataD = issue.opA & issue.opB;
            opLui:   dataD = issue.opB;
            opAuipc: dataD = sum;
            opJal: begin
                dataD     = issue.addr + linkOffset;  // link value
                jumpEnD   = 1'b1;
                jumpAddrD = sum;
            end
            opJalr: begin
                dataD     = issue.addr + linkOffset;
                jumpEnD   = 1'b1;
                jumpAddrD = sum & jalrMask;
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // result register, idle values when nothing issued
    always_ff @(posedge clk) begin
        if (!rstN) begin
            result.valid  <= 1'b0;
            result.jumpEn <= 1'b0;
        end else begin
            result.valid  <= fire;
            result.jumpEn <= fire & jumpEnD;
        end
    end

    always_ff @(posedge clk) begin
        result.tag      <= fire ? issue.tag : tagFree;
        result.data     <= fire ? dataD : dataFree;
        result.jumpAddr <= fire ? jumpAddrD : addrFree;
    end

endmodule

`default_nettype wire

// File: logic/execCore.sv
// Execute cluster top
`timescale 1ns/1ps
`default_nettype none

module execCore (
    input  logic                           clk,
    input  logic                           rstN,
    // dispatch
    input  logic                           dispValid,
    output logic                           dispReady,
    input  execPkg::opCodeT                dispOp,
    input  logic [execPkg::nameWidth-1:0]  dispName,
    input  logic [execPkg::addrWidth-1:0]  dispAddr,
    input  logic [execPkg::dataWidth-1:0]  dispAValue,
    input  logic [execPkg::tagWidth-1:0]   dispATag,
    input  logic                           dispAWait,
    input  logic [execPkg::dataWidth-1:0]  dispBValue,
    input  logic [execPkg::tagWidth-1:0]   dispBTag,
    input  logic                           dispBWait,
    // commit
    output logic                           commitValid,
    input  logic                           commitReady,
    output logic [execPkg::tagWidth-1:0]   commitTag,
    output logic [execPkg::nameWidth-1:0]  commitName,
    output logic [execPkg::dataWidth-1:0]  commitData,
    output logic                           commitJumpEn,
    output logic [execPkg::addrWidth-1:0]  commitJumpAddr
);
    import execPkg::*;

    logic                 rsReady;
    logic                 rsValid;
    logic [tagWidth-1:0]  rsTag;
    logic [dataWidth-1:0] rsAValue;
    logic                 rsAWait;
    logic [dataWidth-1:0] rsBValue;
    logic                 rsBWait;

    issueIf  issueBus ();
    resultIf cdbBus ();

    // --------------------------------------------------
    reorderBuffer rob_i (
        .clk, .rstN,
        .dispValid, .dispReady, .dispName,
        .dispAValue, .dispATag, .dispAWait,
        .dispBValue, .dispBTag, .dispBWait,
        .rsReady, .rsValid, .rsTag,
        .rsAValue, .rsAWait, .rsBValue, .rsBWait,
        .cdb (cdbBus.snoop),
        .commitValid, .commitReady, .commitTag, .commitName,
        .commitData, .commitJumpEn, .commitJumpAddr
    );

    // op, name, address and source tags come straight from dispatch
    reservationStation rs_i (
        .clk, .rstN,
        .inValid  (rsValid),
        .inReady  (rsReady),
        .inOp     (dispOp),
        .inName   (dispName),
        .inAddr   (dispAddr),
        .inTag    (rsTag),
        .inAValue (rsAValue),
        .inATag   (dispATag),
        .inAWait  (rsAWait),
        .inBValue (rsBValue),
        .inBTag   (dispBTag),
        .inBWait  (rsBWait),
        .cdb      (cdbBus.snoop),
        .issue    (issueBus.src)
    );

    aluUnit alu_i (
        .clk, .rstN,
        .issue  (issueBus.dst),
        .result (cdbBus.drv)
    );

endmodule

`default_nettype wire

// File: logic/execIf.sv
// Issue and result bus interfaces
`timescale 1ns/1ps
`default_nettype none

// reservation station to alu
interface issueIf;
    import execPkg::*;

    logic                 valid;
    logic                 ready;
    opCodeT               op;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [tagWidth-1:0]  tag;
    logic [nameWidth-1:0] name;
    logic [addrWidth-1:0] addr;

    modport src (output valid, op, opA, opB, tag, name, addr, input ready);
    modport dst (input valid, op, opA, opB, tag, name, addr, output ready);
endinterface

// common data bus, every listener takes every broadcast
interface resultIf;
    import execPkg::*;

    logic                 valid;
    logic [tagWidth-1:0]  tag;
    logic [dataWidth-1:0] data;
    logic                 jumpEn;
    logic [addrWidth-1:0] jumpAddr;

    modport drv (output valid, tag, data, jumpEn, jumpAddr);
    modport snoop (input valid, tag, data, jumpEn, jumpAddr);
endinterface

`default_nettype wire

// File: logic/execPkg.sv
// Execute cluster definitions
`default_nettype none

package execPkg;

    // --------------------------------------------------
    // widths and depths
    localparam int dataWidth  = 32;
    localparam int addrWidth  = 32;
    localparam int nameWidth  = 5;   // architectural register name
    localparam int opWidth    = 4;
    localparam int shamtWidth = 5;   // rv32 shift amount
    localparam int robDepth   = 8;
    localparam int tagWidth   = 3;   // a tag is a rob index
    localparam int rsDepth    = 4;
    localparam int rsIdxWidth = 2;

    // --------------------------------------------------
    // operation codes
    typedef enum logic [opWidth-1:0] {
        opAdd,
        opSub,
        opSll,
        opSlt,
        opSltu,
        opXor,
        opSrl,
        opSra,
        opOr,
        opAnd,
        opLui,      // result is operand b
        opAuipc,    // operand a + operand b
        opJal,
        opJalr
    } opCodeT;

    // jalr target has bit 0 forced low
    localparam logic [addrWidth-1:0] jalrMask   = {{(addrWidth-1){1'b1}}, 1'b0};
    localparam logic [addrWidth-1:0] linkOffset = addrWidth'(4);

    // --------------------------------------------------
    // idle bus values
    localparam logic [tagWidth-1:0]  tagFree  = '0;
    localparam logic [dataWidth-1:0] dataFree = '0;
    localparam logic [addrWidth-1:0] addrFree = '0;
    localparam logic [nameWidth-1:0] nameFree = '0;
    localparam opCodeT               opFree   = opAdd;

endpackage

`default_nettype wire

// File: logic/reorderBuffer.sv
// Reorder buffer
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer (
    input  logic                           clk,
    input  logic                           rstN,
    // dispatch
    input  logic                           dispValid,
    output logic                           dispReady,
    input  logic [execPkg::nameWidth-1:0]  dispName,
    input  logic [execPkg::dataWidth-1:0]  dispAValue,
    input  logic [execPkg::tagWidth-1:0]   dispATag,
    input  logic                           dispAWait,
    input  logic [execPkg::dataWidth-1:0]  dispBValue,
    input  logic [execPkg::tagWidth-1:0]   dispBTag,
    input  logic                           dispBWait,
    // to reservation station
    input  logic                           rsReady,
    output logic                           rsValid,
    output logic [execPkg::tagWidth-1:0]   rsTag,
    output logic [execPkg::dataWidth-1:0]  rsAValue,
    output logic                           rsAWait,
    output logic [execPkg::dataWidth-1:0]  rsBValue,
    output logic                           rsBWait,
    resultIf.snoop                         cdb,
    // commit
    output logic                           commitValid,
    input  logic                           commitReady,
    output logic [execPkg::tagWidth-1:0]   commitTag,
    output logic [execPkg::nameWidth-1:0]  commitName,
    output logic [execPkg::dataWidth-1:0]  commitData,
    output logic                           commitJumpEn,
    output logic [execPkg::addrWidth-1:0]  commitJumpAddr
);
    import execPkg::*;

    logic [tagWidth-1:0]  headQ;
    logic [tagWidth-1:0]  tailQ;
    logic [tagWidth:0]    countQ;
    logic [tagWidth:0]    countD;
    logic                 spaceQ;   // room for one more entry
    logic [robDepth-1:0]  doneQ;
    logic [nameWidth-1:0] nameQ [robDepth];
    logic [dataWidth-1:0] dataQ [robDepth];
    logic [robDepth-1:0]  jumpEnQ;
    logic [addrWidth-1:0] jumpAddrQ [robDepth];
    logic                 alloc;
    logic                 retire;

    // --------------------------------------------------
    // dispatch side
    assign dispReady = spaceQ & rsReady;
    assign rsValid   = dispValid & spaceQ;
    assign alloc     = dispValid & dispReady;
    assign rsTag     = tailQ;

    // a finished producer hands its value over right away,
    // even while it is retiring on this edge
    assign rsAWait  = dispAWait & ~doneQ[dispATag];
    assign rsAValue = (dispAWait && doneQ[dispATag]) ? dataQ[dispATag] : dispAValue;
    assign rsBWait  = dispBWait & ~doneQ[dispBTag];
    assign rsBValue = (dispBWait && doneQ[dispBTag]) ? dataQ[dispBTag] : dispBValue;

    // --------------------------------------------------
    // commit side
    assign commitValid    = (countQ != '0) && doneQ[headQ];
    assign retire         = commitValid & commitReady;
    assign commitTag      = headQ;
    assign commitName     = nameQ[headQ];
    assign commitData     = dataQ[headQ];
    assign commitJumpEn   = jumpEnQ[headQ];
    assign commitJumpAddr = jumpAddrQ[headQ];

    assign countD = countQ + (tagWidth+1)'(alloc) - (tagWidth+1)'(retire);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headQ  <= '0;
            tailQ  <= '0;
            countQ <= '0;
            spaceQ <= 1'b0;
            doneQ  <= '0;
        end else begin
            countQ <= countD;
            spaceQ <= countD != (tagWidth+1)'(robDepth);
            if (alloc) begin
                tailQ        <= tailQ + 1'b1;
                doneQ[tailQ] <= 1'b0;
            end
            if (cdb.valid) doneQ[cdb.tag] <= 1'b1;
            if (retire) begin
                headQ        <= headQ + 1'b1;
                doneQ[headQ] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) nameQ[tailQ] <= dispName;
        if (cdb.valid) begin
            dataQ[cdb.tag]     <= cdb.data;
            jumpEnQ[cdb.tag]   <= cdb.jumpEn;
            jumpAddrQ[cdb.tag] <= cdb.jumpAddr;
        end
    end

endmodule

`default_nettype wire

// File: logic/reservationStation.sv
// Reservation station
`timescale 1ns/1ps
`default_nettype none

module reservationStation (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           inValid,
    output logic                           inReady,
    input  execPkg::opCodeT                inOp,
    input  logic [execPkg::nameWidth-1:0]  inName,
    input  logic [execPkg::addrWidth-1:0]  inAddr,
    input  logic [execPkg::tagWidth-1:0]   inTag,
    input  logic [execPkg::dataWidth-1:0]  inAValue,
    input  logic [execPkg::tagWidth-1:0]   inATag,
    input  logic                           inAWait,
    input  logic [execPkg::dataWidth-1:0]  inBValue,
    input  logic [execPkg::tagWidth-1:0]   inBTag,
    input  logic                           inBWait,
    resultIf.snoop                         cdb,
    issueIf.src                            issue
);
    import execPkg::*;

    logic [rsDepth-1:0]    validQ;
    logic [rsDepth-1:0]    aWaitQ;
    logic [rsDepth-1:0]    bWaitQ;
    logic [rsDepth-1:0]    olderQ [rsDepth];  // bit j set: entry j is older
    opCodeT                opQ [rsDepth];
    logic [nameWidth-1:0]  nameQ [rsDepth];
    logic [addrWidth-1:0]  addrQ [rsDepth];
    logic [tagWidth-1:0]   tagQ [rsDepth];
    logic [tagWidth-1:0]   aTagQ [rsDepth];
    logic [tagWidth-1:0]   bTagQ [rsDepth];
    logic [dataWidth-1:0]  aValQ [rsDepth];
    logic [dataWidth-1:0]  bValQ [rsDepth];

    logic [rsDepth-1:0]    readyVec;
    logic [rsDepth-1:0]    pickVec;
    logic [rsDepth-1:0]    capA;
    logic [rsDepth-1:0]    capB;
    logic [rsIdxWidth-1:0] pickIdx;
    logic [rsIdxWidth-1:0] freeIdx;
    logic                  write;
    logic                  fire;
    logic                  newCapA;
    logic                  newCapB;

    // --------------------------------------------------
    // oldest ready entry wins
    assign readyVec = validQ & ~aWaitQ & ~bWaitQ;

    always_comb begin
        pickVec = '0;
        pickIdx = '0;
        for (int i = 0; i < rsDepth; i++) begin
            if (readyVec[i] && !(|(olderQ[i] & readyVec))) begin
                pickVec[i] = 1'b1;
                pickIdx    = rsIdxWidth'(i);
            end
        end
    end

    always_comb begin
        freeIdx = '0;
        for (int i = rsDepth - 1; i >= 0; i--) begin
            if (!validQ[i]) freeIdx = rsIdxWidth'(i);
        end
    end

    assign inReady = ~&validQ;
    assign write   = inValid & inReady;
    assign fire    = issue.valid & issue.ready;

    // broadcast snooping, also for the entry arriving now
    always_comb begin
        for (int i = 0; i < rsDepth; i++) begin
            capA[i] = validQ[i] && aWaitQ[i] && cdb.valid && (aTagQ[i] == cdb.tag);
            capB[i] = validQ[i] && bWaitQ[i] && cdb.valid && (bTagQ[i] == cdb.tag);
        end
    end
    assign newCapA = inAWait && cdb.valid && (inATag == cdb.tag);
    assign newCapB = inBWait && cdb.valid && (inBTag == cdb.tag);

    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= '0;
            aWaitQ <= '0;
            bWaitQ <= '0;
            for (int i = 0; i < rsDepth; i++) olderQ[i] <= '0;
        end else begin
            aWaitQ <= aWaitQ & ~capA;
            bWaitQ <= bWaitQ & ~capB;
            if (fire) validQ[pickIdx] <= 1'b0;
            if (write) begin
                validQ[freeIdx] <= 1'b1;
                aWaitQ[freeIdx] <= inAWait & ~newCapA;
                bWaitQ[freeIdx] <= inBWait & ~newCapB;
                olderQ[freeIdx] <= validQ;  // everything present is older
                for (int i = 0; i < rsDepth; i++) olderQ[i][freeIdx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rsDepth; i++) begin
            if (capA[i]) aValQ[i] <= cdb.data;
            if (capB[i]) bValQ[i] <= cdb.data;
        end
        if (write) begin
            opQ[freeIdx]   <= inOp;
            nameQ[freeIdx] <= inName;
            addrQ[freeIdx] <= inAddr;
            tagQ[freeIdx]  <= inTag;
            aTagQ[freeIdx] <= inATag;
            bTagQ[freeIdx] <= inBTag;
            aValQ[freeIdx] <= newCapA ? cdb.data : inAValue;
            bValQ[freeIdx] <= newCapB ? cdb.data : inBValue;
        end
    end

    // --------------------------------------------------
    // issue port
    assign issue.valid = |pickVec;

    always_comb begin
        if (issue.valid) begin
            issue.op   = opQ[pickIdx];
            issue.opA  = aValQ[pickIdx];
            issue.opB  = bValQ[pickIdx];
            issue.tag  = tagQ[pickIdx];
            issue.name = nameQ[pickIdx];
            issue.addr = addrQ[pickIdx];
        end else begin
            issue.op   = opFree;
            issue.opA  = dataFree;
            issue.opB  = dataFree;
            issue.tag  = tagFree;
            issue.name = nameFree;
            issue.addr = addrFree;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the execute cluster simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module execCoreTb \
    -f execCore.f \
    -o execCoreSim

./obj_dir/execCoreSim > sim.log
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

// File: tb/execCoreTb.sv
// Execute cluster testbench
`timescale 1ns/1ps
`default_nettype none

module execCoreTb;
    import execPkg::*;

    logic                 clk;
    logic                 rstN;
    logic                 dispValid;
    logic                 dispReady;
    opCodeT               dispOp;
    logic [nameWidth-1:0] dispName;
    logic [addrWidth-1:0] dispAddr;
    logic [dataWidth-1:0] dispAValue;
    logic [tagWidth-1:0]  dispATag;
    logic                 dispAWait;
    logic [dataWidth-1:0] dispBValue;
    logic [tagWidth-1:0]  dispBTag;
    logic                 dispBWait;
    logic                 commitValid;
    logic                 commitReady;
    logic [tagWidth-1:0]  commitTag;
    logic [nameWidth-1:0] commitName;
    logic [dataWidth-1:0] commitData;
    logic                 commitJumpEn;
    logic [addrWidth-1:0] commitJumpAddr;

    // reference model, dispatched and not yet committed, oldest first
    logic [dataWidth-1:0] expData [$];
    logic [nameWidth-1:0] expName [$];
    logic                 expJumpEn [$];
    logic [addrWidth-1:0] expJumpAddr [$];
    int                   dispCount;
    int                   commitCount;

    // instruction offered on the dispatch port
    logic                 havePend;
    opCodeT               pOp;
    logic [nameWidth-1:0] pName;
    logic [addrWidth-1:0] pAddr;
    logic [dataWidth-1:0] pAVal;   // true operand values
    logic [dataWidth-1:0] pBVal;
    int                   pAProd;  // producer sequence number, -1 for none
    int                   pBProd;

    int                   curTest;
    int                   genLeft;
    int                   checks;
    int                   errors;
    int                   badTests;
    int                   stretchLeft;
    int                   fails [1:6];
    logic                 holdLow;
    logic                 sawFull;
    logic                 timedOut;

    execCore dut_i (.*);

    always #5 clk = ~clk;

    // --------------------------------------------------
    // reference model, straight from the rv32i rules
    function automatic void modelResult(input opCodeT op, input logic [dataWidth-1:0] a,
                                        input logic [dataWidth-1:0] b,
                                        input logic [addrWidth-1:0] pc,
                                        output logic [dataWidth-1:0] res, output logic jEn,
                                        output logic [addrWidth-1:0] jTgt);
        logic [4:0]             sh;
        logic [2*dataWidth-1:0] ext;
        logic [dataWidth-1:0]   sum;
        sh   = b[4:0];
        ext  = {{dataWidth{a[dataWidth-1]}}, a} >> sh;  // sign filled from the left
        sum  = a + b;
        res  = '0;
        jEn  = 1'b0;
        jTgt = '0;
        case (op)
            opAdd:   res = sum;
            opSub:   res = a + ~b + dataWidth'(1);
            opSll:   res = a << sh;
            opSlt:   res = (a[dataWidth-1] != b[dataWidth-1]) ?
                           {{(dataWidth-1){1'b0}}, a[dataWidth-1]} :
                           {{(dataWidth-1){1'b0}}, a < b};
            opSltu:  res = {{(dataWidth-1){1'b0}}, a < b};
            opXor:   res = a ^ b;
            opSrl:   res = a >> sh;
            opSra:   res = ext[dataWidth-1:0];
            opOr:    res = a | b;
            opAnd:   res = a & b;
            opLui:   res = b;
            opAuipc: res = sum;
            opJal: begin
                res  = pc + addrWidth'(4);
                jEn  = 1'b1;
                jTgt = sum;
            end
            opJalr: begin
                res  = pc + addrWidth'(4);
                jEn  = 1'b1;
                jTgt = {sum[addrWidth-1:1], 1'b0};
            end
            default: res = '0;
        endcase
    endfunction

    // --------------------------------------------------
    // compare tasks
    task automatic checkData(input string sig, input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            fails[curTest]++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic checkName(input string sig, input logic [nameWidth-1:0] got,
                             input logic [nameWidth-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            fails[2]++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic checkTag(input string sig, input logic [tagWidth-1:0] got,
                            input logic [tagWidth-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            fails[2]++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic checkJump(input logic gotEn, input logic [addrWidth-1:0] gotAddr,
                             input logic expEn, input logic [addrWidth-1:0] expAddr);
        checks++;
        if (gotEn !== expEn) begin
            errors++;
            fails[4]++;
            $display("CHECK FAILED at %0t: commitJumpEn got %b expected %b",
                     $time, gotEn, expEn);
        end else if (expEn && gotAddr !== expAddr) begin
            errors++;
            fails[4]++;
            $display("CHECK FAILED at %0t: commitJumpAddr got %h expected %h",
                     $time, gotAddr, expAddr);
        end
    endtask

    // --------------------------------------------------
    // per-edge work
    task automatic checkCommit();
        if (expData.size() == 0) begin
            errors++;
            fails[2]++;
            $display("commit at %0t with no instruction outstanding", $time);
        end else begin
            checkTag("commitTag", commitTag, tagWidth'(commitCount % robDepth));
            checkName("commitName", commitName, expName[0]);
            checkData("commitData", commitData, expData[0]);
            checkJump(commitJumpEn, commitJumpAddr, expJumpEn[0], expJumpAddr[0]);
            expData.delete(0);
            expName.delete(0);
            expJumpEn.delete(0);
            expJumpAddr.delete(0);
            commitCount++;
        end
    endtask

    task automatic acceptPending();
        logic [dataWidth-1:0] res;
        logic                 jEn;
        logic [addrWidth-1:0] jTgt;
        modelResult(pOp, pAVal, pBVal, pAddr, res, jEn, jTgt);
        expData.push_back(res);
        expName.push_back(pName);
        expJumpEn.push_back(jEn);
        expJumpAddr.push_back(jTgt);
        dispCount++;
        havePend = 1'b0;
    endtask

    task automatic makePending();
        logic [opWidth-1:0] code;
        int                 qn;
        qn = expData.size();
        if (curTest == 4 && ($urandom % 2) != 0)
            code = (($urandom % 2) != 0) ? opWidth'(opJal) : opWidth'(opJalr);
        else if (curTest == 5)
            code = opWidth'($urandom % 14);
        else
            code = opWidth'($urandom % 12);  // no jumps
        pOp    = opCodeT'(code);
        pName  = nameWidth'($urandom);
        pAddr  = addrWidth'($urandom) & ~addrWidth'(3);
        pAVal  = dataWidth'($urandom);
        pBVal  = dataWidth'($urandom);
        pAProd = -1;
        pBProd = -1;
        if (curTest != 1 && qn > 0 && ($urandom % 2) != 0) begin
            pAProd = commitCount + int'($urandom % qn);
            pAVal  = expData[pAProd - commitCount];
        end
        if (curTest != 1 && qn > 0 && ($urandom % 2) != 0) begin
            pBProd = commitCount + int'($urandom % qn);
            pBVal  = expData[pBProd - commitCount];
        end
        havePend = 1'b1;
        genLeft--;
    endtask

    // a producer that has retired meanwhile is handed over as a value
    task automatic driveDispatch();
        logic aWait;
        logic bWait;
        aWait = pAProd >= commitCount;
        bWait = pBProd >= commitCount;
        dispValid  <= havePend;
        dispOp     <= pOp;
        dispName   <= pName;
        dispAddr   <= pAddr;
        dispAWait  <= aWait;
        dispATag   <= aWait ? tagWidth'(pAProd % robDepth) : '0;
        dispAValue <= aWait ? ~pAVal : pAVal;  // junk while waiting
        dispBWait  <= bWait;
        dispBTag   <= bWait ? tagWidth'(pBProd % robDepth) : '0;
        dispBValue <= bWait ? ~pBVal : pBVal;
    endtask

    task automatic driveCommitReady();
        if (curTest == 5) begin
            if (stretchLeft == 0) begin
                holdLow     = !holdLow;
                stretchLeft = holdLow ? 25 + int'($urandom % 20) : 5 + int'($urandom % 10);
            end
            stretchLeft--;
            commitReady <= !holdLow;
        end else begin
            commitReady <= ($urandom % 4) != 0;
        end
    endtask

    // outputs are read before this edge's updates land
    task automatic stepCycle();
        int qn;
        @(posedge clk);
        qn = expData.size();
        if (qn == robDepth && dispReady) begin
            errors++;
            fails[5]++;
            $display("dispReady high at %0t with every reorder-buffer entry in use", $time);
        end
        if (curTest == 5 && qn == robDepth && !dispReady && !commitReady) sawFull = 1'b1;
        if (commitValid && commitReady) checkCommit();
        if (dispValid && dispReady) acceptPending();
        if (!havePend && genLeft > 0 && ($urandom % 4) != 0) makePending();
        driveDispatch();
        driveCommitReady();
    endtask

    // --------------------------------------------------
    task automatic runPhase(input int test, input int count);
        int guard;
        curTest = test;
        genLeft = count;
        guard   = 0;
        while (!timedOut && (genLeft > 0 || havePend || expData.size() != 0)) begin
            stepCycle();
            guard++;
            if (guard > count * 40 + 500) begin
                timedOut = 1'b1;
                $display("timeout: test %0d still had instructions outstanding after %0d cycles",
                         test, guard);
            end
        end
    endtask

    task automatic reportTest(input int test, input string what, input int bad);
        if (bad != 0) badTests++;
        $display("test %0d %s: %s, %0d failing checks", test, what,
                 (bad == 0) ? "ok" : "FAIL", bad);
    endtask

    initial begin
        void'($urandom(32'h713f_4b83));
        clk         = 1'b0;
        rstN        = 1'b0;
        dispValid   = 1'b0;
        dispOp      = opAdd;
        dispName    = '0;
        dispAddr    = '0;
        dispAValue  = '0;
        dispATag    = '0;
        dispAWait   = 1'b0;
        dispBValue  = '0;
        dispBTag    = '0;
        dispBWait   = 1'b0;
        commitReady = 1'b0;
        havePend    = 1'b0;
        pOp         = opAdd;
        pAProd      = -1;
        pBProd      = -1;
        holdLow     = 1'b0;
        sawFull     = 1'b0;
        timedOut    = 1'b0;
        stretchLeft = 0;
        curTest     = 1;
        for (int i = 1; i <= 6; i++) fails[i] = 0;

        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        runPhase(1, 80);
        reportTest(1, "independent alu operations", fails[1]);
        runPhase(3, 100);
        reportTest(3, "dependent chains", fails[3]);
        runPhase(4, 80);
        reportTest(4, "jal, jalr and jump flags", fails[4]);
        runPhase(5, 140);
        if (!sawFull && !timedOut) begin
            errors++;
            fails[5]++;
            $display("dispReady never dropped while commits were held back");
        end
        reportTest(5, "commit back-pressure", fails[5]);
        reportTest(2, "commit order, tags and names", fails[2]);

        if (dispCount != 400 || commitCount != 400 || expData.size() != 0 || havePend) begin
            errors++;
            fails[6]++;
            $display("%0d dispatched and %0d committed of 400, %0d still outstanding",
                     dispCount, commitCount, expData.size());
        end
        reportTest(6, "all instructions retired", fails[6]);

        $display("tests 6, failing tests %0d, checks %0d, errors %0d, timeout %0d",
                 badTests, checks, errors, timedOut);
        if (errors == 0 && !timedOut) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
